//--- run_sim.sh
#!/bin/sh
# Build and run the cheat engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_cheat_engine

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f tb.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
	echo "Run passed"
	exit 0
else
	echo "Run failed, see $LOG"
	exit 1
fi

//--- src/cheat_config.svh
//////////////////////////////////////////////////
// Cheat engine configuration
// Slot count, code field widths and the widths
// of the download port and both CPU buses
//////////////////////////////////////////////////

`ifndef CHEAT_CONFIG_SVH
`define CHEAT_CONFIG_SVH

// Code table
`define CHEAT_SLOTS       8
`define CHEAT_FIELD_W     32
`define FLAG_COMPARE_BIT  0

// Download port, 16-bit words at byte offsets 0..14
`define DL_WORD_W         16
`define DL_OFFS_W         4

// CPU buses
`define M68K_ADDR_W       24
`define M68K_DATA_W       16
`define Z80_ADDR_W        16
`define Z80_DATA_W        8

`endif

//--- src/cheat_engine_top.sv
//////////////////////////////////////////////////
// Cheat engine top level
// Download loader feeds the code table, which
// drives one patcher per CPU bus. Cartridge
// type picks the live patcher
//////////////////////////////////////////////////

`include "cheat_config.svh"

module cheat_engine_top (
	input  logic                   clk_sys,
	input  logic                   sys_reset,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  logic [`DL_OFFS_W-1:0]  dl_offs_i,
	input  logic [`DL_WORD_W-1:0]  dl_data_i,
	input  logic                   cheats_en_i,
	input  logic                   sms_mode_i,
	input  logic [`M68K_ADDR_W-1:0] m68k_addr_i,
	input  cheat_pkg::m68k_data_t  m68k_data_i,
	output cheat_pkg::m68k_data_t  m68k_data_o,
	input  logic [`Z80_ADDR_W-1:0] z80_addr_i,
	input  cheat_pkg::z80_data_t   z80_data_i,
	output cheat_pkg::z80_data_t   z80_data_o,
	output logic                   codes_available_o
);

	cheat_pkg::cheat_code_t  new_code;
	logic                    new_code_stb;
	logic                    table_clear;
	cheat_pkg::cheat_code_t  codes [`CHEAT_SLOTS];
	logic [`CHEAT_SLOTS-1:0] slot_valid;

	// Genesis carts patch the 68000, SMS carts the Z80
	logic en_68k;
	logic en_z80;

	assign en_68k            = cheats_en_i & ~sms_mode_i;
	assign en_z80            = cheats_en_i & sms_mode_i;
	assign codes_available_o = |slot_valid;

	cheat_loader u_loader (
		.clk_sys     (clk_sys),
		.sys_reset   (sys_reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_offs_i   (dl_offs_i),
		.dl_data_i   (dl_data_i),
		.code_o      (new_code),
		.code_stb_o  (new_code_stb),
		.clear_o     (table_clear)
	);

	cheat_table u_table (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.code_i       (new_code),
		.code_stb_i   (new_code_stb),
		.clear_i      (table_clear),
		.codes_o      (codes),
		.slot_valid_o (slot_valid)
	);

	cheat_patcher #(.ADDR_W(`M68K_ADDR_W), .data_t(cheat_pkg::m68k_data_t)) u_patch_68k (
		.clk_sys (clk_sys), .sys_reset (sys_reset), .enable_i (en_68k),
		.addr_i (m68k_addr_i), .data_i (m68k_data_i),
		.codes_i (codes), .slot_valid_i (slot_valid), .data_o (m68k_data_o)
	);

	cheat_patcher #(.ADDR_W(`Z80_ADDR_W), .data_t(cheat_pkg::z80_data_t)) u_patch_z80 (
		.clk_sys (clk_sys), .sys_reset (sys_reset), .enable_i (en_z80),
		.addr_i (z80_addr_i), .data_i (z80_data_i),
		.codes_i (codes), .slot_valid_i (slot_valid), .data_o (z80_data_o)
	);

endmodule

//--- src/cheat_loader.sv
//////////////////////////////////////////////////
// Cheat code loader
// Collects eight 16-bit download words into one
// code and strobes it out on the last word.
// Also requests a table clear at the start of a
// download session
//////////////////////////////////////////////////

`include "cheat_config.svh"

module cheat_loader (
	input  logic                   clk_sys,
	input  logic                   sys_reset,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  logic [`DL_OFFS_W-1:0]  dl_offs_i,
	input  logic [`DL_WORD_W-1:0]  dl_data_i,
	output cheat_pkg::cheat_code_t code_o,
	output logic                   code_stb_o,
	output logic                   clear_o
);

	logic dl_wr;
	logic first_wr;

	// Writes only count inside a download
	assign dl_wr = dl_active_i & dl_wr_i;

	//////////////////////////////////////////////////
	// Control strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			code_stb_o <= 1'b0;
			clear_o    <= 1'b0;
			first_wr   <= 1'b1;
		end else begin
			// Last word completes the code
			code_stb_o <= dl_wr && (dl_offs_i == `DL_OFFS_W'(14));
			// Offset 0 of the first code empties the table
			clear_o    <= dl_wr && first_wr && (dl_offs_i == '0);
			if (!dl_active_i)
				first_wr <= 1'b1;
			else if (dl_wr)
				first_wr <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Word assembly, low half of each field first
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			case (dl_offs_i)
				`DL_OFFS_W'(0):  code_o.flags[`DL_WORD_W-1:0]                 <= dl_data_i;
				`DL_OFFS_W'(2):  code_o.flags[`CHEAT_FIELD_W-1:`DL_WORD_W]    <= dl_data_i;
				`DL_OFFS_W'(4):  code_o.addr[`DL_WORD_W-1:0]                  <= dl_data_i;
				`DL_OFFS_W'(6):  code_o.addr[`CHEAT_FIELD_W-1:`DL_WORD_W]     <= dl_data_i;
				`DL_OFFS_W'(8):  code_o.compare[`DL_WORD_W-1:0]               <= dl_data_i;
				`DL_OFFS_W'(10): code_o.compare[`CHEAT_FIELD_W-1:`DL_WORD_W]  <= dl_data_i;
				`DL_OFFS_W'(12): code_o.replace[`DL_WORD_W-1:0]               <= dl_data_i;
				`DL_OFFS_W'(14): code_o.replace[`CHEAT_FIELD_W-1:`DL_WORD_W]  <= dl_data_i;
				// Odd offsets carry nothing
				default: ;
			endcase
		end
	end

endmodule

//--- src/cheat_patcher.sv
//////////////////////////////////////////////////
// Cheat bus patcher
// Matches the CPU read address against every
// valid code and substitutes the replace value.
// Lowest matching slot wins, result is registered
//////////////////////////////////////////////////

`include "cheat_config.svh"

module cheat_patcher #(
	parameter int  ADDR_W = 24,
	parameter type data_t = logic [15:0]
) (
	input  logic                    clk_sys,
	input  logic                    sys_reset,
	input  logic                    enable_i,
	input  logic [ADDR_W-1:0]       addr_i,
	input  data_t                   data_i,
	input  cheat_pkg::cheat_code_t  codes_i [`CHEAT_SLOTS],
	input  logic [`CHEAT_SLOTS-1:0] slot_valid_i,
	output data_t                   data_o
);

	localparam int DATA_W = $bits(data_t);

	logic [`CHEAT_SLOTS-1:0] slot_hit;
	data_t                   patch_data;

	//////////////////////////////////////////////////
	// Per-slot match
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `CHEAT_SLOTS; i++) begin
			slot_hit[i] = slot_valid_i[i] &&
				(codes_i[i].addr[ADDR_W-1:0] == addr_i);
			// Compare flag also requires the old bus value
			if (codes_i[i].flags[`FLAG_COMPARE_BIT] &&
				(codes_i[i].compare[DATA_W-1:0] != data_i))
				slot_hit[i] = 1'b0;
		end
	end

	// Walk down so the lowest slot is applied last
	always_comb begin
		patch_data = data_i;
		for (int i = `CHEAT_SLOTS - 1; i >= 0; i--) begin
			if (slot_hit[i])
				patch_data = data_t'(codes_i[i].replace[DATA_W-1:0]);
		end
	end

	//////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sys_reset)
			data_o <= '0;
		else if (enable_i)
			data_o <= patch_data;
		else
			data_o <= data_i;
	end

endmodule

//--- src/cheat_pkg.sv
//////////////////////////////////////////////////
// Cheat engine types
// Code record as loaded from the download port,
// slot index and the data types of both buses
//////////////////////////////////////////////////

`include "cheat_config.svh"

package cheat_pkg;

	// One code, flags in the top field
	// {flags, address, compare, replace}
	//  127:96 95:64    63:32    31:0
	typedef struct packed {
		logic [`CHEAT_FIELD_W-1:0] flags;
		logic [`CHEAT_FIELD_W-1:0] addr;
		logic [`CHEAT_FIELD_W-1:0] compare;
		logic [`CHEAT_FIELD_W-1:0] replace;
	} cheat_code_t;

	// Slot number inside the code table
	typedef logic [$clog2(`CHEAT_SLOTS)-1:0] slot_idx_t;

	// 68000 data bus
	typedef logic [`M68K_DATA_W-1:0] m68k_data_t;

	// Z80 data bus
	typedef logic [`Z80_DATA_W-1:0] z80_data_t;

endpackage

//--- src/cheat_table.sv
//////////////////////////////////////////////////
// Cheat code table
// Fills slots in load order, keeps a valid mask
// and drops new codes once every slot is taken
//////////////////////////////////////////////////

`include "cheat_config.svh"

module cheat_table (
	input  logic                    clk_sys,
	input  logic                    sys_reset,
	input  cheat_pkg::cheat_code_t  code_i,
	input  logic                    code_stb_i,
	input  logic                    clear_i,
	output cheat_pkg::cheat_code_t  codes_o [`CHEAT_SLOTS],
	output logic [`CHEAT_SLOTS-1:0] slot_valid_o
);

	cheat_pkg::slot_idx_t fill_cnt;
	logic                 full;
	logic                 store;

	// Strobe lands only while a slot is free
	assign store = code_stb_i & ~full & ~clear_i;

	//////////////////////////////////////////////////
	// Fill state and valid mask
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sys_reset || clear_i) begin
			fill_cnt     <= '0;
			full         <= 1'b0;
			slot_valid_o <= '0;
		end else if (store) begin
			slot_valid_o[fill_cnt] <= 1'b1;
			fill_cnt               <= fill_cnt + 1'b1;
			// Counter wraps on the last slot, flag holds it
			if (fill_cnt == cheat_pkg::slot_idx_t'(`CHEAT_SLOTS - 1))
				full <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Code storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (store)
			codes_o[fill_cnt] <= code_i;
	end

endmodule

//--- tb.f
+incdir+src
src/cheat_pkg.sv
src/cheat_loader.sv
src/cheat_table.sv
src/cheat_patcher.sv
src/cheat_engine_top.sv
testbench/tb_cheat_engine.sv

//--- testbench/cheat_input.txt
# load <flags> <addr> <compare> <replace> | clear | avail <name> <expected>
# query <name> <bus> <en,sms bits> <addr> <data or any> <expected or pass>
avail reset_empty 0
load 00000000 00001000 00000000 00001234
avail after_load 1
query uncond_hit m68k 10 001000 any 1234
query uncond_neighbor m68k 10 001002 any pass
load 00000001 00002000 00005555 00007777
query cmp_match m68k 10 002000 5555 7777
query cmp_mismatch m68k 10 002000 1111 1111
load 00000000 0000c123 00000000 0000005a
query z80_hit z80 11 c123 any 5a
query sms_68k_pass m68k 11 001000 any pass
query disabled_68k m68k 00 001000 any pass
query disabled_z80 z80 01 c123 any pass
clear
avail after_clear 0
query cleared_code m68k 10 001000 any pass
load 00000000 00003000 00000000 00000101
load 00000000 00003000 00000000 00000202
load 00000000 00003002 00000000 00000303
load 00000000 00003004 00000000 00000404
load 00000000 00003006 00000000 00000505
load 00000000 00003008 00000000 00000606
load 00000000 0000300a 00000000 00000707
load 00000000 0000300c 00000000 00000808
load 00000000 00004000 00000000 00000909
query low_slot_wins m68k 10 003000 any 0101
query table_full m68k 10 004000 any pass

//--- testbench/tb_cheat_engine.sv
//////////////////////////////////////////////////
// Cheat engine testbench
// Replays load, clear, query and avail records
// from the input file against the top level and
// checks bus outputs and code availability
//////////////////////////////////////////////////

`include "cheat_config.svh"

module tb_cheat_engine;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD        = 40;
	localparam int CYCLES_PER_RECORD = 20;

	logic                     clk_sys;
	logic                     sys_reset;
	logic                     dl_active_i;
	logic                     dl_wr_i;
	logic [`DL_OFFS_W-1:0]    dl_offs_i;
	logic [`DL_WORD_W-1:0]    dl_data_i;
	logic                     cheats_en_i;
	logic                     sms_mode_i;
	logic [`M68K_ADDR_W-1:0]  m68k_addr_i;
	cheat_pkg::m68k_data_t    m68k_data_i;
	cheat_pkg::m68k_data_t    m68k_data_o;
	logic [`Z80_ADDR_W-1:0]   z80_addr_i;
	cheat_pkg::z80_data_t     z80_data_i;
	cheat_pkg::z80_data_t     z80_data_o;
	logic                     codes_available_o;

	string records[$];
	int    errors;
	int    checks;
	bit    records_ready;

	cheat_engine_top u_cheat_engine_top (
		.clk_sys           (clk_sys),
		.sys_reset         (sys_reset),
		.dl_active_i       (dl_active_i),
		.dl_wr_i           (dl_wr_i),
		.dl_offs_i         (dl_offs_i),
		.dl_data_i         (dl_data_i),
		.cheats_en_i       (cheats_en_i),
		.sms_mode_i        (sms_mode_i),
		.m68k_addr_i       (m68k_addr_i),
		.m68k_data_i       (m68k_data_i),
		.m68k_data_o       (m68k_data_o),
		.z80_addr_i        (z80_addr_i),
		.z80_data_i        (z80_data_i),
		.z80_data_o        (z80_data_o),
		.codes_available_o (codes_available_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic compare_result(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// Eight words, low half of each field at the lower offset
	task automatic load_code(input logic [31:0] flags, input logic [31:0] addr,
		input logic [31:0] cmp, input logic [31:0] rep);
		logic [31:0] fields [4];
		fields = '{flags, addr, cmp, rep};
		for (int w = 0; w < 8; w++) begin
			@(negedge clk_sys);
			dl_wr_i   = 1'b1;
			dl_offs_i = `DL_OFFS_W'(2 * w);
			dl_data_i = (w % 2 == 0) ? fields[w / 2][15:0] : fields[w / 2][31:16];
		end
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		@(negedge clk_sys);
	endtask

	// New download session, its first write at offset 0 empties the table
	task automatic clear_table();
		@(negedge clk_sys);
		dl_active_i = 1'b0;
		@(negedge clk_sys);
		dl_active_i = 1'b1;
		dl_wr_i     = 1'b1;
		dl_offs_i   = '0;
		dl_data_i   = '0;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic run_query(input string name, input string bus, input logic [1:0] mode,
		input logic [31:0] addr, input string data_s, input string exp_s);
		logic [15:0] data;
		logic [15:0] exp;
		logic [15:0] act;
		if (data_s == "any")
			data = 16'($urandom);
		else if ($sscanf(data_s, "%h", data) != 1) begin
			errors++;
			$display("Query %s has an unreadable data field: %s", name, data_s);
		end
		if (bus == "z80")
			data[15:8] = 8'h00;
		// Pass-through expects the driven data back
		if (exp_s == "pass")
			exp = data;
		else if ($sscanf(exp_s, "%h", exp) != 1) begin
			errors++;
			$display("Query %s has an unreadable expected field: %s", name, exp_s);
		end
		@(negedge clk_sys);
		cheats_en_i = mode[1];
		sms_mode_i  = mode[0];
		if (bus == "z80") begin
			z80_addr_i = addr[`Z80_ADDR_W-1:0];
			z80_data_i = data[7:0];
		end else begin
			m68k_addr_i = addr[`M68K_ADDR_W-1:0];
			m68k_data_i = data;
		end
		@(negedge clk_sys);
		act = (bus == "z80") ? {8'h00, z80_data_o} : m68k_data_o;
		compare_result(name, 32'(exp), 32'(act));
	endtask

	task automatic run_record(input string line);
		string       cmd;
		string       name;
		string       bus;
		string       data_s;
		string       exp_s;
		logic [31:0] f;
		logic [31:0] a;
		logic [31:0] c;
		logic [31:0] r;
		logic [1:0]  mode;
		logic        exp_avail;
		int          n;
		n = $sscanf(line, "%s", cmd);
		if (cmd == "load") begin
			n = $sscanf(line, "%s %h %h %h %h", cmd, f, a, c, r);
			if (n != 5) begin
				errors++;
				$display("Malformed load record in the input file: %s", line);
			end else begin
				load_code(f, a, c, r);
			end
		end else if (cmd == "clear") begin
			clear_table();
		end else if (cmd == "query") begin
			n = $sscanf(line, "%s %s %s %b %h %s %s", cmd, name, bus, mode, a, data_s, exp_s);
			if (n != 7) begin
				errors++;
				$display("Malformed query record in the input file: %s", line);
			end else begin
				run_query(name, bus, mode, a, data_s, exp_s);
			end
		end else if (cmd == "avail") begin
			n = $sscanf(line, "%s %s %b", cmd, name, exp_avail);
			if (n != 3) begin
				errors++;
				$display("Malformed avail record in the input file: %s", line);
			end else begin
				@(negedge clk_sys);
				compare_result(name, 32'(exp_avail), 32'(codes_available_o));
			end
		end else begin
			errors++;
			$display("Unknown record kind in the input file: %s", cmd);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		int    fd;
		string line;
		string cmd;
		void'($urandom(32'hdcf3_5dc0));
		errors      = 0;
		checks      = 0;
		sys_reset   = 1'b1;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_offs_i   = '0;
		dl_data_i   = '0;
		cheats_en_i = 1'b0;
		sms_mode_i  = 1'b0;
		m68k_addr_i = '0;
		m68k_data_i = '0;
		z80_addr_i  = '0;
		z80_data_i  = '0;
		fd = $fopen("testbench/cheat_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/cheat_input.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			// Skip blank and comment lines
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%s", cmd) == 1 && cmd.substr(0, 0) != "#")
					records.push_back(line);
			end
			$fclose(fd);
			records_ready = 1'b1;
			repeat (4) @(negedge clk_sys);
			sys_reset   = 1'b0;
			dl_active_i = 1'b1;
			foreach (records[i])
				run_record(records[i]);
			@(negedge clk_sys);
			$display("Checks run: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		wait (records_ready);
		#((records.size() + 1) * CYCLES_PER_RECORD * CLK_PERIOD);
		$display("Timeout: the input records did not finish in the expected time");
		$display("Simulation failed");
		$finish;
	end

endmodule
